/* src.f */
+incdir+include
hw/ctrlPkg.sv
hw/functDecoder.sv
hw/mainDecoder.sv
hw/controller.sv
dv/controller_assertions.sv
dv/controllerTb.sv

/* Bender.yml */
package:
  name: controller

sources:
  - files:
      - hw/ctrlPkg.sv
      - hw/functDecoder.sv
      - hw/mainDecoder.sv
      - hw/controller.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/controller_assertions.sv
      - dv/controllerTb.sv

/* include/controllerModel.svh */
`ifndef CONTROLLER_MODEL_SVH
`define CONTROLLER_MODEL_SVH

// Expected control word, packed in the same order as the DUT outputs
function automatic logic [22:0] expectedControl(input logic [31:0] word);
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rt;
    logic [4:0] sa;
    regDst_t    dst;
    logic       src;
    logic       src2;
    logic       toReg;
    logic       wr;
    logic       memR;
    logic       memW;
    logic       br;
    logic       jmp;
    logic       sext;
    logic       shIdx;
    dataType_t  dt;
    aluCtrl_t   alu;
    regClass_t  rc;
    op    = word[31:26];
    rt    = word[20:16];
    sa    = word[10:6];
    fn    = word[5:0];
    dst   = DstRt;
    src   = 1'b0;
    src2  = 1'b0;
    toReg = 1'b0;
    wr    = 1'b0;
    memR  = 1'b0;
    memW  = 1'b0;
    br    = 1'b0;
    jmp   = 1'b0;
    sext  = 1'b0;
    shIdx = 1'b0;
    dt    = DtWord;
    alu   = AluNone;
    rc    = RcNop;
    if (word != 32'h0) begin
        case (op)
            OpSpecial: begin
                dst = DstRd;
                wr  = 1'b1;
                rc  = RcRType;
                case (fn)
                    FnAdd, FnAddu: alu = AluAdd;
                    FnSub:  alu = AluSub;
                    FnAnd:  alu = AluAnd;
                    FnOr:   alu = AluOr;
                    FnNor:  alu = AluNor;
                    FnXor:  alu = AluXor;
                    FnSlt:  alu = AluSlt;
                    FnSltu: alu = AluSltu;
                    FnMovn: alu = AluMovn;
                    FnMovz: alu = AluMovz;
                    FnSllv: alu = AluSll;
                    FnSrav: alu = AluSra;
                    FnSrlv: alu = (sa == 5'd0) ? AluSrl : (sa == 5'd1) ? AluRotr : AluNone;
                    FnSll, FnSrl, FnSra: begin
                        src2  = 1'b1;
                        shIdx = 1'b1;
                        rc    = RcShiftImm;
                        if (fn == FnSll) begin
                            alu = AluSll;
                        end else if (fn == FnSra) begin
                            alu = AluSra;
                        end else begin
                            // Bit 21 picks rotate over logical shift
                            alu = word[21] ? AluRotr : AluSrl;
                        end
                    end
                    FnJr: begin
                        jmp = 1'b1;
                        rc  = RcJr;
                    end
                    default: alu = AluNone;
                endcase
            end
            OpSpecial2: begin
                dst = DstRd;
                wr  = 1'b1;
                rc  = RcRType;
                alu = (fn == FnMul) ? AluMul : AluNone;
            end
            OpSpecial3: begin
                dst = DstRd;
                wr  = 1'b1;
                rc  = RcShiftImm;
                alu = (sa == 5'b11000) ? AluSeh : (sa == 5'b10000) ? AluSeb : AluNone;
            end
            OpRegimm: begin
                br  = 1'b1;
                rc  = RcBranchRs;
                alu = (rt == 5'd1) ? AluBgez : (rt == 5'd0) ? AluBltz : AluNone;
            end
            OpBlez, OpBgtz: begin
                br = 1'b1;
                rc = RcBranchRs;
            end
            OpBeq, OpBne: begin
                br = 1'b1;
                rc = RcBranchRsRt;
            end
            OpLw, OpLh, OpLb: begin
                src   = 1'b1;
                toReg = 1'b1;
                wr    = 1'b1;
                memR  = 1'b1;
                alu   = AluAdd;
                rc    = RcLoad;
                dt    = (op == OpLw) ? DtWord : (op == OpLh) ? DtHalf : DtByte;
            end
            OpLui: begin
                src = 1'b1;
                wr  = 1'b1;
                alu = AluAdd;
                rc  = RcLoad;
            end
            OpSw, OpSh, OpSb: begin
                src  = 1'b1;
                memW = 1'b1;
                alu  = AluAdd;
                rc   = RcStore;
                dt   = (op == OpSw) ? DtWord : (op == OpSh) ? DtHalf : DtByte;
            end
            OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori: begin
                src  = 1'b1;
                wr   = 1'b1;
                rc   = RcIType;
                sext = (op == OpAndi) || (op == OpOri) || (op == OpXori);
                case (op)
                    OpSlti:  alu = AluSlt;
                    OpSltiu: alu = AluSltu;
                    OpAndi:  alu = AluAnd;
                    OpOri:   alu = AluOr;
                    OpXori:  alu = AluXor;
                    default: alu = AluAdd;
                endcase
            end
            OpJ, OpJal: begin
                jmp  = 1'b1;
                src2 = 1'b1;
                rc   = RcJump;
                if (op == OpJal) begin
                    wr  = 1'b1;
                    dst = DstRa;
                end
            end
            default: rc = RcNop;
        endcase
    end
    return {dst, src, src2, toReg, wr, memR, memW, br, jmp, sext, shIdx, dt, alu, rc};
endfunction

`endif

/* dv/controllerTb.sv */
module controllerTb import ctrlPkg::*; ();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 16;
    localparam int NumInstr    = 3000;
    localparam int EdgeTries   = 4;

    `include "controllerModel.svh"

    logic       Clk;
    logic       arstN;
    instrWord_t instr;
    regDst_t    regDst;
    logic       aluSrc;
    logic       aluSrc2;
    logic       memToReg;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       branch;
    logic       jump;
    logic       signExtend;
    logic       shiftIndex;
    dataType_t  dataType;
    aluCtrl_t   aluControl;
    regClass_t  regClass;

    logic [22:0] actualWord;
    logic [31:0] lfsrState;

    opcode_t knownOps [24] = '{OpSpecial, OpRegimm, OpSpecial2, OpSpecial3, OpJ, OpJal,
                              OpBeq, OpBne, OpBlez, OpBgtz, OpAddi, OpAddiu, OpSlti,
                              OpSltiu, OpAndi, OpOri, OpXori, OpLui, OpLb, OpLh, OpLw,
                              OpSb, OpSh, OpSw};
    funct_t knownFuncts [18] = '{FnAdd, FnAddu, FnSub, FnAnd, FnOr, FnNor, FnXor, FnSll,
                                 FnSllv, FnSrl, FnSrlv, FnSra, FnSrav, FnSlt, FnSltu,
                                 FnMovn, FnMovz, FnJr};

    controller u_controller (
        .Clk        (Clk),
        .arstN      (arstN),
        .instr      (instr),
        .regDst     (regDst),
        .aluSrc     (aluSrc),
        .aluSrc2    (aluSrc2),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .branch     (branch),
        .jump       (jump),
        .signExtend (signExtend),
        .shiftIndex (shiftIndex),
        .dataType   (dataType),
        .aluControl (aluControl),
        .regClass   (regClass)
    );

    assign actualWord = {regDst, aluSrc, aluSrc2, memToReg, regWrite, memRead, memWrite,
                         branch, jump, signExtend, shiftIndex, dataType, aluControl, regClass};

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic failRun(input string what);
        $display("ERROR: %s", what);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            failRun("control word differs from the model");
        end
    endtask

    task automatic waitFallingEdge();
        bit seen;
        int tries;
        seen  = 1'b0;
        tries = 0;
        while (!seen && tries < EdgeTries) begin
            fork
                begin
                    @(negedge Clk);
                    seen = 1'b1;
                end
                #(2 * ClkPeriod);
            join_any
            disable fork;
            tries++;
        end
        if (!seen) begin
            failRun("no falling clock edge within the timeout");
        end
    endtask

    // Kind first, then the fields that the kind leaves open
    task automatic makeInstr(output logic [31:0] word, output string kind);
        logic [31:0] sel;
        logic [31:0] fields;
        logic [31:0] pick;
        drawBits(3, sel);
        drawBits(26, fields);
        drawBits(5, pick);
        case (sel[2:0])
            3'd0: begin
                word = {knownOps[pick % 24], fields[25:0]};
                kind = "opcode";
            end
            3'd1, 3'd2: begin
                word = {OpSpecial, fields[25:0]};
                if (pick < 18) begin
                    word[5:0] = knownFuncts[pick];
                end
                // Small shamt so srlv and rotrv show up
                if (sel[0]) begin
                    word[10:7] = 4'd0;
                end
                kind = "special";
            end
            3'd3: begin
                word = {OpRegimm, fields[25:0]};
                if (pick[0]) begin
                    word[20:17] = 4'd0;
                end
                kind = "regimm";
            end
            3'd4: begin
                word = {(pick[1:0] == 2'd2) ? OpSpecial2 : OpSpecial3, fields[25:0]};
                case (pick[1:0])
                    2'd0: word[10:6] = 5'b11000;
                    2'd1: word[10:6] = 5'b10000;
                    2'd2: word[5:0]  = FnMul;
                    default: word[10:6] = fields[4:0];
                endcase
                kind = "special2/3";
            end
            3'd5: begin
                word = 32'h0;
                kind = "zero word";
            end
            default: begin
                drawBits(6, sel);
                word = {sel[5:0], fields[25:0]};
                kind = "random word";
            end
        endcase
    endtask

    initial begin
        logic [22:0] expected;
        logic [31:0] word;
        string       kind;
        string       name;
        lfsrState  = 32'd4999;
        arstN      = 1'b0;
        instr      = '0;
        for (int c = 0; c < ResetCycles; c++) begin
            waitFallingEdge();
            checkValue("reset", expectedControl(32'h0), actualWord);
        end
        arstN    = 1'b1;
        expected = expectedControl(32'h0);
        name     = "after reset";
        for (int n = 0; n < NumInstr; n++) begin
            waitFallingEdge();
            checkValue(name, expected, actualWord);
            makeInstr(word, kind);
            instr    = word;
            expected = expectedControl(word);
            name     = $sformatf("%s %0d instr %h", kind, n, word);
        end
        waitFallingEdge();
        checkValue(name, expected, actualWord);
        $display("Test passed");
        $finish;
    end

endmodule

/* dv/controller_assertions.sv */
module controller_assertions (
    input logic Clk,
    input logic arstN,
    input logic memRead,
    input logic memWrite,
    input logic memToReg,
    input logic branch,
    input logic jump
);

    // A single access per instruction
    noLoadAndStore: assert property (@(posedge Clk) disable iff (!arstN)
        !(memRead && memWrite))
        else $error("memRead and memWrite set together");

    noBranchAndJump: assert property (@(posedge Clk) disable iff (!arstN)
        !(branch && jump))
        else $error("branch and jump set together");

    // Write-back from memory only after a read
    memToRegNeedsRead: assert property (@(posedge Clk) disable iff (!arstN)
        memToReg |-> memRead)
        else $error("memToReg set without memRead");

endmodule

bind controller controller_assertions u_controllerAssertions (
    .Clk      (Clk),
    .arstN    (arstN),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .branch   (branch),
    .jump     (jump)
);

/* hw/controller.sv */
module controller import ctrlPkg::*; (
    input  logic       Clk,
    input  logic       arstN,
    input  instrWord_t instr,
    output regDst_t    regDst,
    output logic       aluSrc,
    output logic       aluSrc2,
    output logic       memToReg,
    output logic       regWrite,
    output logic       memRead,
    output logic       memWrite,
    output logic       branch,
    output logic       jump,
    output logic       signExtend,
    output logic       shiftIndex,
    output dataType_t  dataType,
    output aluCtrl_t   aluControl,
    output regClass_t  regClass
);

    logic      isNop;
    aluCtrl_t  specialAlu;
    logic      specialShiftImm;
    logic      specialJr;
    regClass_t specialClass;
    aluCtrl_t  special2Alu;
    aluCtrl_t  regimmAlu;
    aluCtrl_t  special3Alu;

    // Decoded control word before the pipeline register
    regDst_t   decRegDst;
    logic      decAluSrc;
    logic      decAluSrc2;
    logic      decMemToReg;
    logic      decRegWrite;
    logic      decMemRead;
    logic      decMemWrite;
    logic      decBranch;
    logic      decJump;
    logic      decSignExtend;
    logic      decShiftIndex;
    dataType_t decDataType;
    aluCtrl_t  decAluControl;
    regClass_t decRegClass;

    // Only the full zero word is a nop, sll with fields set is not
    assign isNop = (instr == {InstrWidth{1'b0}});

    functDecoder u_functDecoder (
        .funct           (instr.r.funct),
        .shamt           (instr.r.shamt),
        .rsLow           (instr.r.rs[0]),
        .rt              (instr.r.rt),
        .specialAlu      (specialAlu),
        .specialShiftImm (specialShiftImm),
        .specialJr       (specialJr),
        .specialClass    (specialClass),
        .special2Alu     (special2Alu),
        .regimmAlu       (regimmAlu),
        .special3Alu     (special3Alu)
    );

    mainDecoder u_mainDecoder (
        .opcode          (instr.i.opcode),
        .isNop           (isNop),
        .specialAlu      (specialAlu),
        .specialShiftImm (specialShiftImm),
        .specialJr       (specialJr),
        .specialClass    (specialClass),
        .special2Alu     (special2Alu),
        .regimmAlu       (regimmAlu),
        .special3Alu     (special3Alu),
        .regDst          (decRegDst),
        .aluSrc          (decAluSrc),
        .aluSrc2         (decAluSrc2),
        .memToReg        (decMemToReg),
        .regWrite        (decRegWrite),
        .memRead         (decMemRead),
        .memWrite        (decMemWrite),
        .branch          (decBranch),
        .jump            (decJump),
        .signExtend      (decSignExtend),
        .shiftIndex      (decShiftIndex),
        .dataType        (decDataType),
        .aluControl      (decAluControl),
        .regClass        (decRegClass)
    );

    // Decode to execute register, resets to the nop word
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            regDst     <= DstRt;
            aluSrc     <= 1'b0;
            aluSrc2    <= 1'b0;
            memToReg   <= 1'b0;
            regWrite   <= 1'b0;
            memRead    <= 1'b0;
            memWrite   <= 1'b0;
            branch     <= 1'b0;
            jump       <= 1'b0;
            signExtend <= 1'b0;
            shiftIndex <= 1'b0;
            dataType   <= DtWord;
            aluControl <= AluNone;
            regClass   <= RcNop;
        end else begin
            regDst     <= decRegDst;
            aluSrc     <= decAluSrc;
            aluSrc2    <= decAluSrc2;
            memToReg   <= decMemToReg;
            regWrite   <= decRegWrite;
            memRead    <= decMemRead;
            memWrite   <= decMemWrite;
            branch     <= decBranch;
            jump       <= decJump;
            signExtend <= decSignExtend;
            shiftIndex <= decShiftIndex;
            dataType   <= decDataType;
            aluControl <= decAluControl;
            regClass   <= decRegClass;
        end
    end

endmodule

/* hw/mainDecoder.sv */
module mainDecoder import ctrlPkg::*; (
    input  opcode_t   opcode,
    input  logic      isNop,
    input  aluCtrl_t  specialAlu,
    input  logic      specialShiftImm,
    input  logic      specialJr,
    input  regClass_t specialClass,
    input  aluCtrl_t  special2Alu,
    input  aluCtrl_t  regimmAlu,
    input  aluCtrl_t  special3Alu,
    output regDst_t   regDst,
    output logic      aluSrc,
    output logic      aluSrc2,
    output logic      memToReg,
    output logic      regWrite,
    output logic      memRead,
    output logic      memWrite,
    output logic      branch,
    output logic      jump,
    output logic      signExtend,
    output logic      shiftIndex,
    output dataType_t dataType,
    output aluCtrl_t  aluControl,
    output regClass_t regClass
);

    dataType_t accessWidth;
    aluCtrl_t  immAlu;
    logic      immLogic;

    // Memory access width shared by loads and stores
    always_comb begin
        case (opcode)
            OpLh, OpSh: accessWidth = DtHalf;
            OpLb, OpSb: accessWidth = DtByte;
            default:    accessWidth = DtWord;
        endcase
    end

    // I-format ALU op, logic ops also flag signExtend
    always_comb begin
        immLogic = 1'b0;
        case (opcode)
            OpSlti:  immAlu = AluSlt;
            OpSltiu: immAlu = AluSltu;
            OpAndi: begin
                immAlu   = AluAnd;
                immLogic = 1'b1;
            end
            OpOri: begin
                immAlu   = AluOr;
                immLogic = 1'b1;
            end
            OpXori: begin
                immAlu   = AluXor;
                immLogic = 1'b1;
            end
            default: immAlu = AluAdd;
        endcase
    end

    always_comb begin
        // Nop word unless a known opcode says otherwise
        regDst     = DstRt;
        aluSrc     = 1'b0;
        aluSrc2    = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        signExtend = 1'b0;
        shiftIndex = 1'b0;
        dataType   = DtWord;
        aluControl = AluNone;
        regClass   = RcNop;
        if (!isNop) begin
            case (opcode)
                OpSpecial: begin
                    // jr also lands here, its rd field is zero
                    regDst     = DstRd;
                    regWrite   = 1'b1;
                    aluSrc2    = specialShiftImm;
                    shiftIndex = specialShiftImm;
                    jump       = specialJr;
                    aluControl = specialAlu;
                    regClass   = specialClass;
                end
                OpSpecial2: begin
                    regDst     = DstRd;
                    regWrite   = 1'b1;
                    aluControl = special2Alu;
                    regClass   = RcRType;
                end
                OpSpecial3: begin
                    regDst     = DstRd;
                    regWrite   = 1'b1;
                    aluControl = special3Alu;
                    regClass   = RcShiftImm;
                end
                OpLw, OpLh, OpLb: begin
                    aluSrc     = 1'b1;
                    memToReg   = 1'b1;
                    regWrite   = 1'b1;
                    memRead    = 1'b1;
                    dataType   = accessWidth;
                    aluControl = AluAdd;
                    regClass   = RcLoad;
                end
                OpLui: begin
                    aluSrc     = 1'b1;
                    regWrite   = 1'b1;
                    aluControl = AluAdd;
                    regClass   = RcLoad;
                end
                OpSw, OpSh, OpSb: begin
                    aluSrc     = 1'b1;
                    memWrite   = 1'b1;
                    dataType   = accessWidth;
                    aluControl = AluAdd;
                    regClass   = RcStore;
                end
                OpRegimm: begin
                    branch     = 1'b1;
                    aluControl = regimmAlu;
                    regClass   = RcBranchRs;
                end
                OpBlez, OpBgtz: begin
                    branch   = 1'b1;
                    regClass = RcBranchRs;
                end
                OpBeq, OpBne: begin
                    branch   = 1'b1;
                    regClass = RcBranchRsRt;
                end
                OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori: begin
                    aluSrc     = 1'b1;
                    regWrite   = 1'b1;
                    signExtend = immLogic;
                    aluControl = immAlu;
                    regClass   = RcIType;
                end
                OpJ: begin
                    jump     = 1'b1;
                    aluSrc2  = 1'b1;
                    regClass = RcJump;
                end
                OpJal: begin
                    // Link into r31
                    jump     = 1'b1;
                    aluSrc2  = 1'b1;
                    regWrite = 1'b1;
                    regDst   = DstRa;
                    regClass = RcJump;
                end
                default: regClass = RcNop;
            endcase
        end
    end

endmodule

/* hw/functDecoder.sv */
module functDecoder import ctrlPkg::*; (
    input  funct_t              funct,
    input  logic [RegWidth-1:0] shamt,
    input  logic                rsLow,
    input  logic [RegWidth-1:0] rt,
    output aluCtrl_t            specialAlu,
    output logic                specialShiftImm,
    output logic                specialJr,
    output regClass_t           specialClass,
    output aluCtrl_t            special2Alu,
    output aluCtrl_t            regimmAlu,
    output aluCtrl_t            special3Alu
);

    // SPECIAL table, unknown functs fall through as R type with no ALU op
    always_comb begin
        specialAlu      = AluNone;
        specialShiftImm = 1'b0;
        specialJr       = 1'b0;
        specialClass    = RcRType;
        case (funct)
            FnAdd, FnAddu: specialAlu = AluAdd;
            FnSub:         specialAlu = AluSub;
            FnAnd:         specialAlu = AluAnd;
            FnOr:          specialAlu = AluOr;
            FnNor:         specialAlu = AluNor;
            FnXor:         specialAlu = AluXor;
            FnSlt:         specialAlu = AluSlt;
            FnSltu:        specialAlu = AluSltu;
            FnMovn:        specialAlu = AluMovn;
            FnMovz:        specialAlu = AluMovz;
            FnSllv:        specialAlu = AluSll;
            FnSrav:        specialAlu = AluSra;
            FnSll: begin
                specialAlu      = AluSll;
                specialShiftImm = 1'b1;
                specialClass    = RcShiftImm;
            end
            FnSrl: begin
                // rs bit 0 selects rotate
                specialAlu      = rsLow ? AluRotr : AluSrl;
                specialShiftImm = 1'b1;
                specialClass    = RcShiftImm;
            end
            FnSra: begin
                specialAlu      = AluSra;
                specialShiftImm = 1'b1;
                specialClass    = RcShiftImm;
            end
            FnSrlv: begin
                // Variable form keys off shamt instead
                if (shamt == 5'd0) begin
                    specialAlu = AluSrl;
                end else if (shamt == 5'd1) begin
                    specialAlu = AluRotr;
                end
            end
            FnJr: begin
                specialJr    = 1'b1;
                specialClass = RcJr;
            end
            default: specialAlu = AluNone;
        endcase
    end

    // SPECIAL2 only carries mul
    assign special2Alu = (funct == FnMul) ? AluMul : AluNone;

    always_comb begin
        case (rt)
            RtBgez:  regimmAlu = AluBgez;
            RtBltz:  regimmAlu = AluBltz;
            default: regimmAlu = AluNone;
        endcase
    end

    // seh and seb differ only in shamt
    always_comb begin
        case (shamt)
            ShSeh:   special3Alu = AluSeh;
            ShSeb:   special3Alu = AluSeb;
            default: special3Alu = AluNone;
        endcase
    end

endmodule

/* hw/ctrlPkg.sv */
package ctrlPkg;

    // Instruction field widths
    localparam int InstrWidth  = 32;
    localparam int OpcodeWidth = 6;
    localparam int RegWidth    = 5;
    localparam int FunctWidth  = 6;
    localparam int ImmWidth    = 16;

    typedef logic [OpcodeWidth-1:0] opcode_t;
    typedef logic [FunctWidth-1:0]  funct_t;
    typedef logic [4:0]             aluCtrl_t;
    typedef logic [3:0]             regClass_t;
    typedef logic [1:0]             dataType_t;
    typedef logic [1:0]             regDst_t;

    // Primary opcodes
    localparam opcode_t OpSpecial  = 6'b000000;
    localparam opcode_t OpRegimm   = 6'b000001;
    localparam opcode_t OpJ        = 6'b000010;
    localparam opcode_t OpJal      = 6'b000011;
    localparam opcode_t OpBeq      = 6'b000100;
    localparam opcode_t OpBne      = 6'b000101;
    localparam opcode_t OpBlez     = 6'b000110;
    localparam opcode_t OpBgtz     = 6'b000111;
    localparam opcode_t OpAddi     = 6'b001000;
    localparam opcode_t OpAddiu    = 6'b001001;
    localparam opcode_t OpSlti     = 6'b001010;
    localparam opcode_t OpSltiu    = 6'b001011;
    localparam opcode_t OpAndi     = 6'b001100;
    localparam opcode_t OpOri      = 6'b001101;
    localparam opcode_t OpXori     = 6'b001110;
    localparam opcode_t OpLui      = 6'b001111;
    localparam opcode_t OpSpecial2 = 6'b011100;
    localparam opcode_t OpSpecial3 = 6'b011111;
    localparam opcode_t OpLb       = 6'b100000;
    localparam opcode_t OpLh       = 6'b100001;
    localparam opcode_t OpLw       = 6'b100011;
    localparam opcode_t OpSb       = 6'b101000;
    localparam opcode_t OpSh       = 6'b101001;
    localparam opcode_t OpSw       = 6'b101011;

    // SPECIAL functs, FnMul lives under SPECIAL2
    localparam funct_t FnSll  = 6'b000000;
    localparam funct_t FnSrl  = 6'b000010;
    localparam funct_t FnSra  = 6'b000011;
    localparam funct_t FnSllv = 6'b000100;
    localparam funct_t FnSrlv = 6'b000110;
    localparam funct_t FnSrav = 6'b000111;
    localparam funct_t FnJr   = 6'b001000;
    localparam funct_t FnMovz = 6'b001010;
    localparam funct_t FnMovn = 6'b001011;
    localparam funct_t FnAdd  = 6'b100000;
    localparam funct_t FnAddu = 6'b100001;
    localparam funct_t FnSub  = 6'b100010;
    localparam funct_t FnAnd  = 6'b100100;
    localparam funct_t FnOr   = 6'b100101;
    localparam funct_t FnXor  = 6'b100110;
    localparam funct_t FnNor  = 6'b100111;
    localparam funct_t FnSlt  = 6'b101010;
    localparam funct_t FnSltu = 6'b101011;
    localparam funct_t FnMul  = 6'b000010;

    // REGIMM rt codes and SPECIAL3 shamt codes
    localparam logic [RegWidth-1:0] RtBltz = 5'b00000;
    localparam logic [RegWidth-1:0] RtBgez = 5'b00001;
    localparam logic [RegWidth-1:0] ShSeb  = 5'b10000;
    localparam logic [RegWidth-1:0] ShSeh  = 5'b11000;

    // ALU operation codes, shared with the execute stage
    localparam aluCtrl_t AluAdd  = 5'd0;
    localparam aluCtrl_t AluSub  = 5'd1;
    localparam aluCtrl_t AluAnd  = 5'd3;
    localparam aluCtrl_t AluOr   = 5'd4;
    localparam aluCtrl_t AluNor  = 5'd5;
    localparam aluCtrl_t AluXor  = 5'd6;
    localparam aluCtrl_t AluSll  = 5'd7;
    localparam aluCtrl_t AluSrl  = 5'd8;
    localparam aluCtrl_t AluRotr = 5'd9;
    localparam aluCtrl_t AluSlt  = 5'd10;
    localparam aluCtrl_t AluMovn = 5'd11;
    localparam aluCtrl_t AluMovz = 5'd12;
    localparam aluCtrl_t AluSra  = 5'd13;
    localparam aluCtrl_t AluSltu = 5'd14;
    localparam aluCtrl_t AluMul  = 5'd19;
    localparam aluCtrl_t AluSeh  = 5'd22;
    localparam aluCtrl_t AluSeb  = 5'd23;
    localparam aluCtrl_t AluBgez = 5'd24;
    localparam aluCtrl_t AluBltz = 5'd25;
    localparam aluCtrl_t AluNone = 5'd31;

    // Register usage classes for the hazard unit
    localparam regClass_t RcRType      = 4'd0;
    localparam regClass_t RcIType      = 4'd1;
    localparam regClass_t RcLoad       = 4'd3;
    localparam regClass_t RcStore      = 4'd4;
    localparam regClass_t RcBranchRs   = 4'd5;
    localparam regClass_t RcBranchRsRt = 4'd6;
    localparam regClass_t RcJump       = 4'd7;
    localparam regClass_t RcJr         = 4'd8;
    localparam regClass_t RcShiftImm   = 4'd9;
    localparam regClass_t RcNop        = 4'd11;

    localparam dataType_t DtWord = 2'd0;
    localparam dataType_t DtHalf = 2'd1;
    localparam dataType_t DtByte = 2'd2;

    localparam regDst_t DstRt = 2'd0;
    localparam regDst_t DstRd = 2'd1;
    localparam regDst_t DstRa = 2'd2;

    // One instruction word seen as R format or I format
    typedef union packed {
        struct packed {
            opcode_t             opcode;
            logic [RegWidth-1:0] rs;
            logic [RegWidth-1:0] rt;
            logic [RegWidth-1:0] rd;
            logic [RegWidth-1:0] shamt;
            funct_t              funct;
        } r;
        struct packed {
            opcode_t             opcode;
            logic [RegWidth-1:0] rs;
            logic [RegWidth-1:0] rt;
            logic [ImmWidth-1:0] imm;
        } i;
    } instrWord_t;

endpackage
